/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := audio_mixer_tb
FILELIST := sim.f

MDIR    := obj_dir
BIN     := $(MDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(MDIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(MDIR)

/* common/audio_defines.svh */
/*
 * Audio mixer constants
 * Sample and accumulator widths, plus the two knee curves
 * used by the output compressor
 */

`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// One source or output sample
`define AUDIO_SAMPLE_W 16
// Mixing sum, two bits of headroom over a sample
`define AUDIO_ACC_W    18

//////////////////////////////////////////////////
// Compressor curves
//////////////////////////////////////////////////

// Soft curve, x2 below the knee and /4 above
`define COMP1_KNEE 14044
`define COMP1_GAIN 2
`define COMP1_DIV  4
`define COMP1_BASE 28088

// Hard curve, x4 below the knee and /8 above
`define COMP2_KNEE 7400
`define COMP2_GAIN 4
`define COMP2_DIV  8
`define COMP2_BASE 29600

`endif

/* common/audio_pkg.sv */
/*
 * Audio mixer types
 * Sample, accumulator and compressor setting words
 */

`default_nettype none

`include "audio_defines.svh"

package audio_pkg;

	// Signed PCM sample as produced by each sound source
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// Signed mixing sum
	typedef logic signed [`AUDIO_ACC_W-1:0] acc_t;

	// Compressor setting
	// Zero is off, any other value compresses, upper bit picks the hard curve
	typedef logic [1:0] comp_mode_t;

endpackage

`default_nettype wire

/* common/audio_stage_if.sv */
/*
 * Link between two mixer pipeline stages
 * Carries one stereo sum and the settings that belong to it
 */

`timescale 1ns/1ps
`default_nettype none

interface audio_stage_if;
	import audio_pkg::*;

	acc_t       left;
	acc_t       right;
	// Settings travel with the sample they apply to
	logic       cdda_boost;
	comp_mode_t comp_mode;

	// Writing stage
	modport source (
		output left,
		output right,
		output cdda_boost,
		output comp_mode
	);

	// Reader that needs the boost flag
	modport sink (
		input left,
		input right,
		input cdda_boost,
		input comp_mode
	);

	// Compressor only looks at the sample and its mode
	modport comp_sink (
		input left,
		input right,
		input comp_mode
	);

endinterface

`default_nettype wire

/* mixer/audio_mixer_top.sv */
/*
 * Final sound mixer
 * Three-stage pipeline: source sum, 5/4 headroom scaling
 * and optional dynamic-range compression
 */

`timescale 1ns/1ps
`default_nettype none

module audio_mixer_top (
	input  logic                  clk_sys,
	input  logic                  reset,

	// Already filtered sources
	input  audio_pkg::sample_t    cdda_l,
	input  audio_pkg::sample_t    cdda_r,
	input  audio_pkg::sample_t    psg_l,
	input  audio_pkg::sample_t    psg_r,
	input  audio_pkg::sample_t    adpcm,

	// Per-source enables and mix settings
	input  logic                  cdda_en,
	input  logic                  psg_en,
	input  logic                  adpcm_en,
	input  logic                  cdda_boost,
	input  audio_pkg::comp_mode_t comp_mode,

	// Signed output, three cycles after the inputs
	output audio_pkg::sample_t    audio_l,
	output audio_pkg::sample_t    audio_r
);

	//////////////////////////////////////////////////
	// Stage links
	//////////////////////////////////////////////////

	audio_stage_if sum_link ();
	audio_stage_if scale_link ();

	//////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////

	source_summer i_source_summer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cdda_l     (cdda_l),
		.cdda_r     (cdda_r),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.adpcm      (adpcm),
		.cdda_en    (cdda_en),
		.psg_en     (psg_en),
		.adpcm_en   (adpcm_en),
		.cdda_boost (cdda_boost),
		.comp_mode  (comp_mode),
		.out_link   (sum_link.source)
	);

	headroom_scaler i_headroom_scaler (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_link  (sum_link.sink),
		.out_link (scale_link.source)
	);

	dynamic_compressor i_dynamic_compressor (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in_link (scale_link.comp_sink),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

`default_nettype wire

/* mixer/dynamic_compressor.sv */
/*
 * Mixer stage 3
 * Takes the top 16 bits of the sum and optionally runs them
 * through a soft or hard knee compressor curve
 */

`timescale 1ns/1ps
`default_nettype none

`include "audio_defines.svh"

module dynamic_compressor (
	input  logic                  clk_sys,
	input  logic                  reset,
	audio_stage_if.comp_sink      in_link,
	output audio_pkg::sample_t    audio_l,
	output audio_pkg::sample_t    audio_r
);
	import audio_pkg::*;

	// Curve constants cut down to sample width
	localparam logic [`AUDIO_SAMPLE_W-1:0] soft_knee = `COMP1_KNEE;
	localparam logic [`AUDIO_SAMPLE_W-1:0] soft_gain = `COMP1_GAIN;
	localparam logic [`AUDIO_SAMPLE_W-1:0] soft_div  = `COMP1_DIV;
	localparam logic [`AUDIO_SAMPLE_W-1:0] soft_base = `COMP1_BASE;
	localparam logic [`AUDIO_SAMPLE_W-1:0] hard_knee = `COMP2_KNEE;
	localparam logic [`AUDIO_SAMPLE_W-1:0] hard_gain = `COMP2_GAIN;
	localparam logic [`AUDIO_SAMPLE_W-1:0] hard_div  = `COMP2_DIV;
	localparam logic [`AUDIO_SAMPLE_W-1:0] hard_base = `COMP2_BASE;

	// Linear gain below the knee, flattened slope above it
	function automatic logic [`AUDIO_SAMPLE_W-1:0] knee_curve(
		input logic [`AUDIO_SAMPLE_W-1:0] m,
		input logic [`AUDIO_SAMPLE_W-1:0] knee,
		input logic [`AUDIO_SAMPLE_W-1:0] gain,
		input logic [`AUDIO_SAMPLE_W-1:0] div,
		input logic [`AUDIO_SAMPLE_W-1:0] base
	);
		if (m < knee)
			knee_curve = m * gain;
		else
			knee_curve = (m - knee) / div + base;
	endfunction

	// Works on the magnitude and puts the sign back afterwards
	function automatic sample_t compress(input sample_t s, input logic hard);
		logic [`AUDIO_SAMPLE_W-1:0] m;
		logic [`AUDIO_SAMPLE_W-1:0] v_soft;
		logic [`AUDIO_SAMPLE_W-1:0] v_hard;
		logic [`AUDIO_SAMPLE_W-1:0] v;

		m = s[`AUDIO_SAMPLE_W-1] ? ~s + 1'b1 : s;
		v_soft = knee_curve(m, soft_knee, soft_gain, soft_div, soft_base);
		v_hard = knee_curve(m, hard_knee, hard_gain, hard_div, hard_base);
		v = hard ? v_hard : v_soft;
		compress = s[`AUDIO_SAMPLE_W-1] ? ~(v - 1'b1) : v;
	endfunction

	sample_t in_l;
	sample_t in_r;
	logic    comp_on;
	logic    comp_hard;
	sample_t next_l;
	sample_t next_r;

	// Drop the two headroom bits
	assign in_l = in_link.left[`AUDIO_ACC_W-1 -: `AUDIO_SAMPLE_W];
	assign in_r = in_link.right[`AUDIO_ACC_W-1 -: `AUDIO_SAMPLE_W];

	assign comp_on   = |in_link.comp_mode;
	assign comp_hard = in_link.comp_mode[1];

	assign next_l = comp_on ? compress(in_l, comp_hard) : in_l;
	assign next_r = comp_on ? compress(in_r, comp_hard) : in_r;

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= next_l;
			audio_r <= next_r;
		end
	end

endmodule

`default_nettype wire

/* mixer/headroom_scaler.sv */
/*
 * Mixer stage 2
 * Scales the sum by 5/4 to use the full output range,
 * skipped when CD boost already doubled the CD share
 */

`timescale 1ns/1ps
`default_nettype none

module headroom_scaler (
	input  logic          clk_sys,
	input  logic          reset,
	audio_stage_if.sink   in_link,
	audio_stage_if.source out_link
);
	import audio_pkg::*;

	// x + x/4, wraps in the accumulator width
	function automatic acc_t scale(input acc_t s, input logic boost);
		if (boost)
			scale = s;
		else
			scale = s + (s >>> 2);
	endfunction

	acc_t scaled_l;
	acc_t scaled_r;

	assign scaled_l = scale(in_link.left, in_link.cdda_boost);
	assign scaled_r = scale(in_link.right, in_link.cdda_boost);

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_link.left       <= '0;
			out_link.right      <= '0;
			out_link.cdda_boost <= 1'b0;
			out_link.comp_mode  <= '0;
		end else begin
			out_link.left       <= scaled_l;
			out_link.right      <= scaled_r;
			// Settings stay with their sample
			out_link.cdda_boost <= in_link.cdda_boost;
			out_link.comp_mode  <= in_link.comp_mode;
		end
	end

endmodule

`default_nettype wire

/* mixer/source_summer.sv */
/*
 * Mixer stage 1
 * Sums the enabled CD, PSG and ADPCM sources per channel,
 * adding CD audio a second time when the boost is on
 */

`timescale 1ns/1ps
`default_nettype none

`include "audio_defines.svh"

module source_summer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  audio_pkg::sample_t     cdda_l,
	input  audio_pkg::sample_t     cdda_r,
	input  audio_pkg::sample_t     psg_l,
	input  audio_pkg::sample_t     psg_r,
	input  audio_pkg::sample_t     adpcm,
	input  logic                   cdda_en,
	input  logic                   psg_en,
	input  logic                   adpcm_en,
	input  logic                   cdda_boost,
	input  audio_pkg::comp_mode_t  comp_mode,
	audio_stage_if.source          out_link
);
	import audio_pkg::*;

	// Sign-extend a sample into the accumulator, or zero when muted
	function automatic acc_t widen(input sample_t s, input logic en);
		widen = en ? {{(`AUDIO_ACC_W - `AUDIO_SAMPLE_W){s[`AUDIO_SAMPLE_W-1]}}, s} : '0;
	endfunction

	logic cdda_twice;
	acc_t sum_l;
	acc_t sum_r;

	// Boost only means something while CD audio is enabled
	assign cdda_twice = cdda_en & cdda_boost;

	// ADPCM is mono and lands in both channels
	assign sum_l = widen(cdda_l, cdda_en) + widen(cdda_l, cdda_twice)
		+ widen(psg_l, psg_en) + widen(adpcm, adpcm_en);
	assign sum_r = widen(cdda_r, cdda_en) + widen(cdda_r, cdda_twice)
		+ widen(psg_r, psg_en) + widen(adpcm, adpcm_en);

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_link.left       <= '0;
			out_link.right      <= '0;
			out_link.cdda_boost <= 1'b0;
			out_link.comp_mode  <= '0;
		end else begin
			out_link.left       <= sum_l;
			out_link.right      <= sum_r;
			out_link.cdda_boost <= cdda_boost;
			out_link.comp_mode  <= comp_mode;
		end
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/audio_pkg.sv
common/audio_stage_if.sv
mixer/source_summer.sv
mixer/headroom_scaler.sv
mixer/dynamic_compressor.sv
mixer/audio_mixer_top.sv
verification/audio_mixer_tb.sv

/* verification/audio_mixer_tb.sv */
/*
 * Testbench for the final sound mixer
 * Random and directed stimulus against a reference model,
 * checked three cycles later through a delay line
 */

`timescale 1ns/1ps
`default_nettype none

`include "audio_defines.svh"

module audio_mixer_tb;
	import audio_pkg::*;

	localparam int drain_timeout = 20;

	logic       clk_sys;
	logic       reset;
	sample_t    cdda_l;
	sample_t    cdda_r;
	sample_t    psg_l;
	sample_t    psg_r;
	sample_t    adpcm;
	logic       cdda_en;
	logic       psg_en;
	logic       adpcm_en;
	logic       cdda_boost;
	comp_mode_t comp_mode;
	sample_t    audio_l;
	sample_t    audio_r;

	logic [31:0] rng_state;
	int          error_count;
	int          check_count;
	int          pushed_count;
	int          checked_count;
	logic        stim_done;
	logic        timed_out;

	// Expected outputs, entry 2 is the oldest
	sample_t exp_l [0:2];
	sample_t exp_r [0:2];
	logic    exp_v [0:2];

	audio_mixer_top i_audio_mixer_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cdda_l     (cdda_l),
		.cdda_r     (cdda_r),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.adpcm      (adpcm),
		.cdda_en    (cdda_en),
		.psg_en     (psg_en),
		.adpcm_en   (adpcm_en),
		.cdda_boost (cdda_boost),
		.comp_mode  (comp_mode),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Knee curve on the magnitude, sign restored at the end
	function automatic sample_t compress_ref(input sample_t x, input logic hard);
		integer      xi;
		integer      mag;
		integer      knee;
		integer      gain;
		integer      div;
		integer      base;
		integer      r;
		logic [15:0] res;
		xi   = x;
		knee = hard ? `COMP2_KNEE : `COMP1_KNEE;
		gain = hard ? `COMP2_GAIN : `COMP1_GAIN;
		div  = hard ? `COMP2_DIV : `COMP1_DIV;
		base = hard ? `COMP2_BASE : `COMP1_BASE;
		mag  = (xi < 0) ? -xi : xi;
		if (mag < knee)
			r = mag * gain;
		else
			r = (mag - knee) / div + base;
		res = r[15:0];
		if (x[15])
			res = ~(res - 16'd1);
		return sample_t'(res);
	endfunction

	// One output channel from one input set
	function automatic sample_t mix_channel(
		input sample_t    cdda,
		input sample_t    psg,
		input sample_t    voice,
		input logic       ce,
		input logic       pe,
		input logic       ae,
		input logic       bst,
		input comp_mode_t mode
	);
		integer      sum;
		logic [31:0] scaled;
		sample_t     top;
		sum = 0;
		if (ce)
			sum = sum + cdda;
		if (ce && bst)
			sum = sum + cdda;
		if (pe)
			sum = sum + psg;
		if (ae)
			sum = sum + voice;
		// 5/4 gain, wrapping at 18 bits
		scaled = bst ? sum : sum + (sum >>> 2);
		top = scaled[17:2];
		if (mode == 2'd0)
			return top;
		return compress_ref(top, mode[1]);
	endfunction

	task automatic check_output(input string name, input sample_t actual,
		input sample_t expected);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("ERROR: time %0t, %s expected %h, actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic check_zero_outputs();
		check_output("audio_l", audio_l, '0);
		check_output("audio_r", audio_r, '0);
	endtask

	//////////////////////////////////////////////////
	// Delay line and compare
	//////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		#0.5;
		if (reset) begin
			check_zero_outputs();
			for (int i = 0; i < 3; i++) begin
				exp_l[i] = '0;
				exp_r[i] = '0;
				exp_v[i] = 1'b0;
			end
		end else begin
			for (int i = 2; i > 0; i--) begin
				exp_l[i] = exp_l[i-1];
				exp_r[i] = exp_r[i-1];
				exp_v[i] = exp_v[i-1];
			end
			// Inputs just taken by the DUT at this edge
			exp_l[0] = mix_channel(cdda_l, psg_l, adpcm, cdda_en, psg_en, adpcm_en,
				cdda_boost, comp_mode);
			exp_r[0] = mix_channel(cdda_r, psg_r, adpcm, cdda_en, psg_en, adpcm_en,
				cdda_boost, comp_mode);
			exp_v[0] = !stim_done;
			if (!stim_done)
				pushed_count++;
			// Output register now holds the inputs taken two edges back
			check_output("audio_l", audio_l, exp_l[2]);
			check_output("audio_r", audio_r, exp_r[2]);
			if (exp_v[2])
				checked_count++;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic random_word(output logic [31:0] w);
		rng_state = xorshift32(rng_state);
		w = rng_state;
	endtask

	task automatic set_random_inputs(input logic ce, input logic pe, input logic ae,
		input logic bst, input comp_mode_t mode);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		random_word(w0);
		random_word(w1);
		random_word(w2);
		cdda_l     = w0[15:0];
		cdda_r     = w0[31:16];
		psg_l      = w1[15:0];
		psg_r      = w1[31:16];
		adpcm      = w2[15:0];
		cdda_en    = ce;
		psg_en     = pe;
		adpcm_en   = ae;
		cdda_boost = bst;
		comp_mode  = mode;
	endtask

	task automatic run_random(input int count, input logic ce, input logic pe,
		input logic ae, input logic bst, input comp_mode_t mode);
		repeat (count) begin
			@(posedge clk_sys);
			#1;
			set_random_inputs(ce, pe, ae, bst, mode);
		end
	endtask

	// Settings drawn fresh on every cycle
	task automatic run_mixed(input int count);
		logic [31:0] w;
		repeat (count) begin
			random_word(w);
			@(posedge clk_sys);
			#1;
			set_random_inputs(w[0], w[1], w[2], w[3], w[5:4]);
		end
	endtask

	// Boosted full mix of one level gives 4*v, so v reaches the compressor as is
	task automatic drive_level(input sample_t v, input comp_mode_t mode);
		@(posedge clk_sys);
		#1;
		cdda_l     = v;
		cdda_r     = v;
		psg_l      = v;
		psg_r      = v;
		adpcm      = v;
		cdda_en    = 1'b1;
		psg_en     = 1'b1;
		adpcm_en   = 1'b1;
		cdda_boost = 1'b1;
		comp_mode  = mode;
	endtask

	task automatic sweep_extremes(input comp_mode_t mode);
		drive_level(16'h7FFF, mode);
		drive_level(16'h8000, mode);
		drive_level(16'h0000, mode);
		drive_level(sample_t'(`COMP1_KNEE), mode);
		drive_level(sample_t'(`COMP1_KNEE - 1), mode);
		drive_level(sample_t'(`COMP1_KNEE + 1), mode);
		drive_level(sample_t'(-`COMP1_KNEE), mode);
		drive_level(sample_t'(`COMP2_KNEE), mode);
		drive_level(sample_t'(`COMP2_KNEE - 1), mode);
		drive_level(sample_t'(`COMP2_KNEE + 1), mode);
		drive_level(sample_t'(-`COMP2_KNEE), mode);
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		timed_out = 1'b0;
		while (checked_count < pushed_count && !timed_out) begin
			@(posedge clk_sys);
			#1;
			cycles++;
			if (cycles >= drain_timeout && checked_count < pushed_count)
				timed_out = 1'b1;
		end
	endtask

	initial begin
		rng_state     = 32'h49c5;
		error_count   = 0;
		check_count   = 0;
		pushed_count  = 0;
		checked_count = 0;
		stim_done     = 1'b0;
		timed_out     = 1'b0;
		reset         = 1'b1;
		cdda_l        = '0;
		cdda_r        = '0;
		psg_l         = '0;
		psg_r         = '0;
		adpcm         = '0;
		cdda_en       = 1'b0;
		psg_en        = 1'b0;
		adpcm_en      = 1'b0;
		cdda_boost    = 1'b0;
		comp_mode     = '0;

		// Three reset edges, then zeros for three cycles
		repeat (3) @(posedge clk_sys);
		#0.5;
		check_zero_outputs();
		#0.5;
		reset = 1'b0;
		set_random_inputs(1'b1, 1'b1, 1'b1, 1'b0, 2'd0);
		repeat (2) begin
			@(posedge clk_sys);
			#0.5;
			check_zero_outputs();
		end

		run_random(200, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0);
		// One source muted at a time
		run_random(50, 1'b0, 1'b1, 1'b1, 1'b0, 2'd0);
		run_random(50, 1'b1, 1'b0, 1'b1, 1'b0, 2'd0);
		run_random(50, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0);
		run_random(100, 1'b1, 1'b1, 1'b1, 1'b1, 2'd0);
		run_random(100, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1);
		run_random(100, 1'b1, 1'b1, 1'b1, 1'b1, 2'd2);
		sweep_extremes(2'd1);
		sweep_extremes(2'd2);
		run_mixed(300);

		@(posedge clk_sys);
		#1;
		stim_done = 1'b1;
		wait_for_drain();
		if (timed_out)
			$display("Timeout: %0d samples never left the pipeline",
				pushed_count - checked_count);
		$display("Errors: %0d, checks: %0d", error_count, check_count);
		if (!timed_out && error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
